//--- hdl/rast.sv
// Triangle rasterizer top level
`timescale 1ns/10ps

module rast
    import rast_geom_pkg::*;
    import rast_stream_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  tri_packet_t tri_in,
    input  screen_t     screen,  // Held static while running
    output logic        halt,
    output hit_packet_t hit
);

    boxed_packet_t  boxed; // Producer to iterator
    sample_packet_t samp;  // Iterator to sample test

    rast_bbox u_bbox (
        .clk    (clk),
        .rst    (rst),
        .tri_in (tri_in),
        .screen (screen),
        .halt   (halt),
        .boxed  (boxed)
    );

    // Holds one triangle while walking its box
    rast_sample_iter u_iter (
        .clk   (clk),
        .rst   (rst),
        .boxed (boxed),
        .samp  (samp),
        .halt  (halt)
    );

    rast_sample_test u_test (
        .clk  (clk),
        .rst  (rst),
        .samp (samp),
        .hit  (hit)
    );

endmodule

//--- hdl/rast_bbox.sv
// Triangle bounding box stage
`timescale 1ns/10ps

module rast_bbox
    import rast_geom_pkg::*;
    import rast_stream_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  tri_packet_t   tri_in,
    input  screen_t       screen,
    input  logic          halt,
    output boxed_packet_t boxed
);

    vertex_t lo;       // Raw per-axis minimum
    vertex_t hi;       // Raw per-axis maximum
    vertex_t lo_snap;
    vertex_t hi_snap;
    vertex_t limit;    // Last sample on screen
    box_t    box_next;
    logic    accept;
    logic    cull;

    // Round down to the pixel grid
    function automatic coord_t snap(coord_t v);
        return {v[SIGFIG-1:RADIX], {RADIX{1'b0}}};
    endfunction

    function automatic coord_t clamp(coord_t v, coord_t top);
        if (v < 0)
            return '0;
        else if (v > top)
            return top;
        return v;
    endfunction

    assign accept = tri_in.valid && !halt;

    always_comb begin
        lo = tri_in.triangle[0];
        hi = tri_in.triangle[0];
        for (int i = 1; i < VERTS; i++) begin
            if (tri_in.triangle[i].x < lo.x)
                lo.x = tri_in.triangle[i].x;
            if (tri_in.triangle[i].y < lo.y)
                lo.y = tri_in.triangle[i].y;
            if (tri_in.triangle[i].x > hi.x)
                hi.x = tri_in.triangle[i].x;
            if (tri_in.triangle[i].y > hi.y)
                hi.y = tri_in.triangle[i].y;
        end
    end

    assign lo_snap.x = snap(lo.x);
    assign lo_snap.y = snap(lo.y);
    assign hi_snap.x = snap(hi.x);
    assign hi_snap.y = snap(hi.y);

    assign limit.x = screen.width - PIXEL;
    assign limit.y = screen.height - PIXEL;

    // Unclamped box entirely off screen on some axis
    assign cull = (hi_snap.x < 0) || (hi_snap.y < 0) ||
                  (lo_snap.x >= screen.width) || (lo_snap.y >= screen.height);

    assign box_next.min.x = clamp(lo_snap.x, limit.x);
    assign box_next.min.y = clamp(lo_snap.y, limit.y);
    assign box_next.max.x = clamp(hi_snap.x, limit.x);
    assign box_next.max.y = clamp(hi_snap.y, limit.y);

    always_ff @(posedge clk) begin
        if (rst)
            boxed.valid <= 1'b0;
        else
            boxed.valid <= accept && !cull; // Single cycle strobe

        if (accept) begin
            boxed.triangle <= tri_in.triangle;
            boxed.color    <= tri_in.color;
            boxed.box      <= box_next;
        end
    end

endmodule

//--- hdl/rast_geom_pkg.sv
// Rasterizer geometry types
package rast_geom_pkg;

    localparam int SIGFIG = 16; // Bits per coordinate
    localparam int RADIX  = 4;  // Fraction bits, 16 units per pixel
    localparam int VERTS  = 3;  // Vertices per triangle

    // Signed fixed point, RADIX fraction bits
    typedef logic signed [SIGFIG-1:0] coord_t;

    // One pixel step on the sample grid
    localparam coord_t PIXEL = coord_t'(1 << RADIX);

    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;

    // Vertex 0 sits in the low bits
    typedef vertex_t [VERTS-1:0] triangle_t;

    // Inclusive sample range, both corners on the grid
    typedef struct packed {
        vertex_t min;
        vertex_t max;
    } box_t;

    // Screen size in coordinate units
    typedef struct packed {
        coord_t width;
        coord_t height;
    } screen_t;

endpackage

//--- hdl/rast_sample_iter.sv
// Sample iterator over a bounding box
`timescale 1ns/10ps

module rast_sample_iter
    import rast_geom_pkg::*;
    import rast_stream_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  boxed_packet_t  boxed,
    output sample_packet_t samp,
    output logic           halt
);

    iter_state_t state;
    vertex_t     last;       // Box max, final sample of the walk
    coord_t      row_start;  // Box min x for the row wrap
    logic        at_last;
    logic        at_row_end;
    vertex_t     next_sample;

    assign at_last    = (samp.sample == last);
    assign at_row_end = (samp.sample.x == last.x);

    // Raster order, x first then down one row
    always_comb begin
        next_sample = samp.sample;
        if (at_row_end) begin
            next_sample.x = row_start;
            next_sample.y = samp.sample.y + PIXEL;
        end else begin
            next_sample.x = samp.sample.x + PIXEL;
        end
    end

    // Hold off the producer while a walk runs or a box waits
    assign halt = (state == ITER_TEST) || boxed.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ITER_WAIT;
            samp.valid <= 1'b0;
        end else begin
            case (state)
                ITER_WAIT: begin
                    if (boxed.valid) begin
                        state      <= ITER_TEST;
                        samp.valid <= 1'b1; // First sample is box min
                    end
                end
                ITER_TEST: begin
                    if (at_last) begin
                        state      <= ITER_WAIT;
                        samp.valid <= 1'b0;
                    end
                end
                default: begin
                    state      <= ITER_WAIT;
                    samp.valid <= 1'b0;
                end
            endcase
        end
    end

    // Triangle and walk position
    always_ff @(posedge clk) begin
        if (state == ITER_WAIT) begin
            if (boxed.valid) begin
                samp.triangle <= boxed.triangle;
                samp.color    <= boxed.color;
                samp.sample   <= boxed.box.min;
                last          <= boxed.box.max;
                row_start     <= boxed.box.min.x;
            end
        end else if (!at_last) begin
            samp.sample <= next_sample;
        end
    end

endmodule

//--- hdl/rast_sample_test.sv
// Edge function sample test
`timescale 1ns/10ps

module rast_sample_test
    import rast_geom_pkg::*;
    import rast_stream_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  sample_packet_t samp,
    output hit_packet_t    hit
);

    // Difference of two coordinates needs one extra bit
    typedef logic signed [SIGFIG:0] delta_t;
    // Difference of two full products
    typedef logic signed [2*SIGFIG+2:0] cross_t;

    delta_t           edge_x [VERTS];
    delta_t           edge_y [VERTS];
    delta_t           off_x  [VERTS];
    delta_t           off_y  [VERTS];
    cross_t           cross_prod [VERTS];
    logic [VERTS-1:0] on_side;
    logic             covered;

    always_comb begin
        for (int i = 0; i < VERTS; i++) begin
            // Edge from vertex i to the next one with wrap at the end
            edge_x[i] = delta_t'(samp.triangle[(i + 1) % VERTS].x) -
                        delta_t'(samp.triangle[i].x);
            edge_y[i] = delta_t'(samp.triangle[(i + 1) % VERTS].y) -
                        delta_t'(samp.triangle[i].y);
            off_x[i]  = delta_t'(samp.sample.x) - delta_t'(samp.triangle[i].x);
            off_y[i]  = delta_t'(samp.sample.y) - delta_t'(samp.triangle[i].y);

            cross_prod[i] = cross_t'(edge_x[i]) * cross_t'(off_y[i]) -
                            cross_t'(edge_y[i]) * cross_t'(off_x[i]);
            on_side[i]    = (cross_prod[i] <= 0); // Clockwise with edges inclusive
        end
    end

    assign covered = samp.valid && (&on_side);

    always_ff @(posedge clk) begin
        if (rst)
            hit.valid <= 1'b0;
        else
            hit.valid <= covered;

        if (samp.valid) begin
            hit.loc   <= samp.sample;
            hit.color <= samp.color;
        end
    end

endmodule

//--- hdl/rast_stream_pkg.sv
// Rasterizer stage records
package rast_stream_pkg;

    import rast_geom_pkg::*;

    localparam int CHANNEL_BITS = 8;

    typedef logic [CHANNEL_BITS-1:0] channel_t;

    typedef struct packed {
        channel_t r;
        channel_t g;
        channel_t b;
    } color_t;

    // Triangle entering the pipeline
    typedef struct packed {
        logic      valid;
        triangle_t triangle;
        color_t    color;
    } tri_packet_t;

    // Triangle plus its clamped box
    typedef struct packed {
        logic      valid;
        triangle_t triangle;
        color_t    color;
        box_t      box;
    } boxed_packet_t;

    // One sample location to be tested
    typedef struct packed {
        logic      valid;
        triangle_t triangle;
        color_t    color;
        vertex_t   sample;
    } sample_packet_t;

    // Covered sample
    typedef struct packed {
        logic    valid;
        vertex_t loc;
        color_t  color;
    } hit_packet_t;

    typedef enum logic {
        ITER_WAIT,
        ITER_TEST
    } iter_state_t;

endpackage

//--- rast.f
hdl/rast_geom_pkg.sv
hdl/rast_stream_pkg.sv
hdl/rast_bbox.sv
hdl/rast_sample_iter.sv
hdl/rast_sample_test.sv
hdl/rast.sv
verification/rast_checker.sv
verification/rast_tb.sv

//--- verification/rast_checker.sv
// Rasterizer hit scoreboard
`timescale 1ns/10ps

module rast_checker
    import rast_geom_pkg::*;
    import rast_stream_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  tri_packet_t tri_in,
    input  screen_t     screen,
    input  logic        halt,
    input  hit_packet_t hit,
    output int          error_count,
    output int          hit_count,
    output int          pending
);

    typedef struct packed {
        int      due;   // Edge at which the hit is seen
        vertex_t loc;
        color_t  color;
    } exp_hit_t;

    exp_hit_t exp_q[$];
    int       now    = 0;
    int       errors = 0;
    int       hits   = 0;
    logic     rst_q  = 1'b0;

    // Expected hits of one accepted triangle in raster order
    task automatic queue_hits(input tri_packet_t t, input screen_t s, input int start);
        int       vx [VERTS];
        int       vy [VERTS];
        int       lo_x, lo_y, hi_x, hi_y;
        int       top_x, top_y;
        int       k;
        longint   cr;
        bit       covered;
        exp_hit_t e;
        for (int i = 0; i < VERTS; i++) begin
            vx[i] = int'($signed(t.triangle[i].x));
            vy[i] = int'($signed(t.triangle[i].y));
        end
        lo_x = vx[0];
        lo_y = vy[0];
        hi_x = vx[0];
        hi_y = vy[0];
        for (int i = 1; i < VERTS; i++) begin
            lo_x = (vx[i] < lo_x) ? vx[i] : lo_x;
            lo_y = (vy[i] < lo_y) ? vy[i] : lo_y;
            hi_x = (vx[i] > hi_x) ? vx[i] : hi_x;
            hi_y = (vy[i] > hi_y) ? vy[i] : hi_y;
        end
        lo_x  = (lo_x >>> RADIX) <<< RADIX; // Floor to pixel grid
        lo_y  = (lo_y >>> RADIX) <<< RADIX;
        hi_x  = (hi_x >>> RADIX) <<< RADIX;
        hi_y  = (hi_y >>> RADIX) <<< RADIX;
        top_x = int'($signed(s.width)) - PIXEL;
        top_y = int'($signed(s.height)) - PIXEL;
        if (hi_x < 0 || hi_y < 0 || lo_x > top_x || lo_y > top_y)
            return; // Culled
        lo_x = (lo_x < 0) ? 0 : lo_x;
        lo_y = (lo_y < 0) ? 0 : lo_y;
        hi_x = (hi_x > top_x) ? top_x : hi_x;
        hi_y = (hi_y > top_y) ? top_y : hi_y;
        k = 0;
        for (int y = lo_y; y <= hi_y; y += PIXEL) begin
            for (int x = lo_x; x <= hi_x; x += PIXEL) begin
                covered = 1'b1;
                for (int i = 0; i < VERTS; i++) begin
                    cr = longint'(vx[(i + 1) % VERTS] - vx[i]) * longint'(y - vy[i]) -
                         longint'(vy[(i + 1) % VERTS] - vy[i]) * longint'(x - vx[i]);
                    if (cr > 0)
                        covered = 1'b0;
                end
                if (covered) begin
                    e.due   = start + 3 + k; // One sample per cycle after 3 cycle latency
                    e.loc.x = coord_t'(x);
                    e.loc.y = coord_t'(y);
                    e.color = t.color;
                    exp_q.push_back(e);
                end
                k++;
            end
        end
    endtask

    always @(posedge clk) begin
        now = now + 1;
        if (rst) begin
            exp_q.delete();
        end else begin
            if (rst_q && (halt !== 1'b0 || hit.valid !== 1'b0)) begin
                $display("Error halt %h hit.valid %h after reset, expected 0 0", halt, hit.valid);
                errors++;
            end
            while (exp_q.size() > 0 && exp_q[0].due < now) begin
                $display("Expected hit at x %h y %h never arrived", exp_q[0].loc.x,
                         exp_q[0].loc.y);
                errors++;
                void'(exp_q.pop_front());
            end
            if (hit.valid === 1'b1) begin
                if (exp_q.size() == 0 || exp_q[0].due != now) begin
                    $display("Error hit.valid expected 0 got 1 at hit.loc %h", hit.loc);
                    errors++;
                end else begin
                    if (hit.loc !== exp_q[0].loc) begin
                        $display("Error hit.loc expected %h got %h", exp_q[0].loc, hit.loc);
                        errors++;
                    end
                    if (hit.color !== exp_q[0].color) begin
                        $display("Error hit.color expected %h got %h", exp_q[0].color,
                                 hit.color);
                        errors++;
                    end
                    hits++;
                    void'(exp_q.pop_front());
                end
            end
            if (tri_in.valid === 1'b1 && halt === 1'b0)
                queue_hits(tri_in, screen, now); // Accepted on this edge
        end
        rst_q = rst;
        error_count <= errors;
        hit_count   <= hits;
        pending     <= exp_q.size();
    end

endmodule

//--- verification/rast_tb.sv
// Rasterizer testbench
`timescale 1ns/10ps

module rast_tb
    import rast_geom_pkg::*;
    import rast_stream_pkg::*;
();

    localparam int FIXED_ROWS = 6;
    localparam int ROWS       = FIXED_ROWS + 4; // Last rows are random
    localparam int TIMEOUT    = 2000;

    typedef struct packed {
        tri_packet_t pkt;
        screen_t     screen;
    } stim_t;

    logic        clk;
    logic        rst;
    tri_packet_t tri_in;
    screen_t     screen;
    logic        halt;
    hit_packet_t hit;
    int          errors;
    int          matched;
    int          pending;
    stim_t       stim [ROWS];
    int          pts [6];
    integer      seed;
    bit          timed_out;

    rast DUT (.clk(clk), .rst(rst), .tri_in(tri_in), .screen(screen), .halt(halt), .hit(hit));

    rast_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .tri_in      (tri_in),
        .screen      (screen),
        .halt        (halt),
        .hit         (hit),
        .error_count (errors),
        .hit_count   (matched),
        .pending     (pending)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic stim_t make_row(int x0, int y0, int x1, int y1, int x2, int y2,
                                       logic [23:0] rgb, int w, int h);
        stim_t r;
        r.pkt.valid          = 1'b1;
        r.pkt.triangle[0].x  = coord_t'(x0);
        r.pkt.triangle[0].y  = coord_t'(y0);
        r.pkt.triangle[1].x  = coord_t'(x1);
        r.pkt.triangle[1].y  = coord_t'(y1);
        r.pkt.triangle[2].x  = coord_t'(x2);
        r.pkt.triangle[2].y  = coord_t'(y2);
        r.pkt.color          = color_t'(rgb);
        r.screen.width       = coord_t'(w);
        r.screen.height      = coord_t'(h);
        return r;
    endfunction

    // Halt sampled before the edge, low means accepted there
    task automatic wait_accept(output bit late);
        int waited;
        waited = 0;
        late = 1'b0;
        @(posedge clk);
        while (halt !== 1'b0 && !late) begin
            if (waited == TIMEOUT) begin
                $display("Timeout: triangle not accepted within %0d cycles", TIMEOUT);
                late = 1'b1;
            end else begin
                @(posedge clk);
                waited++;
            end
        end
    endtask

    task automatic wait_drain(output bit late);
        int waited;
        waited = 0;
        late = 1'b0;
        @(posedge clk);
        while ((pending != 0 || halt !== 1'b0) && !late) begin
            if (waited == TIMEOUT) begin
                $display("Timeout: expected hits still pending after %0d cycles", TIMEOUT);
                late = 1'b1;
            end else begin
                @(posedge clk);
                waited++;
            end
        end
    endtask

    initial begin
        rst       = 1'b1;
        tri_in    = '0;
        screen    = '0;
        seed      = 79;
        timed_out = 1'b0;
        stim[0] = make_row(16, 16, 16, 120, 120, 16, 24'hff2010, 256, 256);   // Clockwise
        stim[1] = make_row(64, 64, 64, 200, 200, 64, 24'h10ff20, 128, 128);   // Crosses edge
        stim[2] = make_row(-100, -100, -100, -40, -40, -100, 24'h2010ff, 256, 256);
        stim[3] = make_row(16, 16, 120, 16, 16, 120, 24'h808080, 256, 256);   // Wrong winding
        stim[4] = make_row(32, 32, 32, 32, 32, 32, 24'hc0ffee, 256, 256);     // All edges zero
        stim[5] = make_row(48, 48, 48, 100, 100, 48, 24'h00a0a0, 256, 256);
        for (int i = FIXED_ROWS; i < ROWS; i++) begin
            for (int j = 0; j < 6; j++)
                pts[j] = $random(seed) & 255;
            stim[i] = make_row(pts[0], pts[1], pts[2], pts[3], pts[4], pts[5],
                               $random(seed) & 24'hffffff, 256, 256);
        end

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Next row goes out on the edge that took the previous one
        for (int i = 0; i < ROWS && !timed_out; i++) begin
            tri_in <= stim[i].pkt;
            screen <= stim[i].screen;
            wait_accept(timed_out);
        end
        tri_in.valid <= 1'b0;

        if (!timed_out)
            wait_drain(timed_out);
        repeat (4) @(posedge clk); // Catch stray hits
        $display("Errors %0d, hits matched %0d, hits pending %0d", errors, matched, pending);
        if (timed_out || errors != 0)
            $display("Testbench failed");
        else
            $display("Testbench passed");
        $finish;
    end

endmodule
